// ==== vlog.f ====
rtl/iso_link_pkg.sv
rtl/iso_word_if.sv
rtl/byte_packer.sv
rtl/isochronous_spill_register.sv
rtl/byte_unpacker.sv
rtl/iso_byte_link.sv
tests/iso_link_chk.sv
tests/link_monitor.sv
tests/tb_iso_byte_link.sv

// ==== Makefile ====
# Verilator flow for the isochronous byte link

TOP := tb_iso_byte_link
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

# The run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f vlog.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/tb_iso_byte_link.sv ====
/*
 * Testbench for the byte link. Frames from the table are driven in the source
 * domain while the output ready follows a per-frame mode; link_monitor compares.
 */
`timescale 1ns/1ns

module tb_iso_byte_link;

  localparam int timeout_lp  = 2000;
  localparam int n_frames_lp = 21;

  // Ready mode 0 always high, 1 random, 2 long stalls, 3 always high with rate check
  typedef struct packed {
    logic [1:0] mode;
    logic [7:0] nbytes;
    logic [7:0] start;
    logic [3:0] gap;
  } frame_t;

  frame_t frame_tab [n_frames_lp] = '{
    '{2'd0, 8'd4,  8'h10, 4'd0}, '{2'd0, 8'd8,  8'h20, 4'd0}, '{2'd0, 8'd12, 8'h40, 4'd2},
    '{2'd0, 8'd1,  8'h60, 4'd1}, '{2'd0, 8'd2,  8'h64, 4'd1}, '{2'd0, 8'd3,  8'h68, 4'd1},
    '{2'd0, 8'd5,  8'h70, 4'd1}, '{2'd0, 8'd7,  8'h78, 4'd1}, '{2'd2, 8'd24, 8'h80, 4'd0},
    '{2'd2, 8'd9,  8'ha0, 4'd0}, '{2'd1, 8'd13, 8'hb0, 4'd3}, '{2'd1, 8'd1,  8'hc0, 4'd2},
    '{2'd1, 8'd4,  8'hc4, 4'd3}, '{2'd1, 8'd7,  8'hc8, 4'd1}, '{2'd1, 8'd10, 8'hd0, 4'd3},
    '{2'd1, 8'd2,  8'he0, 4'd0}, '{2'd1, 8'd17, 8'he2, 4'd2}, '{2'd1, 8'd3,  8'hf4, 4'd1},
    '{2'd3, 8'd16, 8'h00, 4'd0}, '{2'd3, 8'd16, 8'h10, 4'd0}, '{2'd3, 8'd16, 8'h20, 4'd0}
  };

  logic       src_clk;
  logic       dst_clk;
  logic       arst_n;
  logic       src_valid;
  logic       src_ready;
  logic [7:0] src_data;
  logic       src_last;
  logic       dst_valid;
  logic       dst_ready = 1'b0;
  logic [7:0] dst_data;
  logic       dst_last;

  logic [1:0] ready_mode;
  logic       rate_on;
  logic       run_end;
  logic       aborted;
  logic       saw_src_stall = 1'b0;
  int         tb_errs;
  int         sent_cnt;
  int         stall_len = 0;
  int         dst_cycle = 0;
  int         rate_bytes = 0;
  int         rate_first = 0;
  int         rate_last = 0;
  int         recv_cnt;
  int         data_errs;
  int         last_errs;
  int         misc_errs;

  iso_byte_link uut (
    .src_clk_i   (src_clk),
    .src_valid_i (src_valid),
    .src_ready_o (src_ready),
    .src_data_i  (src_data),
    .src_last_i  (src_last),
    .dst_clk_i   (dst_clk),
    .dst_valid_o (dst_valid),
    .dst_ready_i (dst_ready),
    .dst_data_o  (dst_data),
    .dst_last_o  (dst_last),
    .arst_n_i    (arst_n)
  );

  bind iso_byte_link iso_link_chk u_chk (.*);

  link_monitor u_monitor (
    .src_clk_i   (src_clk),
    .dst_clk_i   (dst_clk),
    .arst_n_i    (arst_n),
    .src_valid_i (src_valid),
    .src_ready_i (src_ready),
    .src_data_i  (src_data),
    .src_last_i  (src_last),
    .dst_valid_i (dst_valid),
    .dst_ready_i (dst_ready),
    .dst_data_i  (dst_data),
    .dst_last_i  (dst_last),
    .end_i       (run_end),
    .recv_cnt_o  (recv_cnt),
    .data_errs_o (data_errs),
    .last_errs_o (last_errs),
    .misc_errs_o (misc_errs)
  );

  // Source clock flips on each rising destination edge, so rising edges line up
  initial begin
    dst_clk = 1'b0;
    src_clk = 1'b0;
    forever begin
      #2 dst_clk = 1'b1;
      src_clk = ~src_clk;
      #2 dst_clk = 1'b0;
    end
  end

  always @(posedge dst_clk) begin
    #1;
    case (ready_mode)
      2'd1: dst_ready = ($urandom & 32'd3) != 0;
      2'd2: begin
        // Low for 80 cycles out of every 100
        stall_len = (stall_len + 1) % 100;
        dst_ready = stall_len >= 80;
      end
      default: dst_ready = 1'b1;
    endcase
  end

  always @(posedge dst_clk) begin
    dst_cycle = dst_cycle + 1;
    if (rate_on && dst_valid && dst_ready) begin
      if (rate_bytes == 0) rate_first = dst_cycle;
      rate_last  = dst_cycle;
      rate_bytes = rate_bytes + 1;
    end
  end

  always @(posedge src_clk) begin
    if (ready_mode == 2'd2 && src_valid && !src_ready) saw_src_stall = 1'b1;
  end

  task automatic expect_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail t=%0t %s expected %b got %b", $time, name, exp, act);
      tb_errs++;
    end
  endtask

  // Sampled at the edge, so src_ready still holds its value from before it
  task automatic wait_accept();
    int n;
    n = 0;
    do begin
      @(posedge src_clk);
      n++;
    end while (!src_ready && n < timeout_lp);
    if (src_ready) begin
      sent_cnt++;
    end else begin
      $display("Timeout at %0t: src_ready_o stayed low for %0d source cycles", $time, n);
      tb_errs++;
      aborted = 1'b1;
    end
    #1;
  endtask

  task automatic send_frame(input frame_t fr);
    int i;
    int gap_n;
    for (i = 0; i < int'(fr.nbytes) && !aborted; i++) begin
      gap_n = int'($urandom % (32'(fr.gap) + 32'd1));
      if (gap_n > 0) src_valid = 1'b0;
      repeat (gap_n) begin
        @(posedge src_clk);
        #1;
      end
      src_valid = 1'b1;
      src_data  = fr.start + 8'(i);
      src_last  = (i == int'(fr.nbytes) - 1);
      wait_accept();
    end
    src_valid = 1'b0;
    src_last  = 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (recv_cnt != sent_cnt && n < timeout_lp) begin
      @(posedge dst_clk);
      n++;
    end
    if (recv_cnt != sent_cnt) begin
      $display("Timeout at %0t: %0d bytes sent, only %0d came out", $time, sent_cnt, recv_cnt);
      tb_errs++;
      aborted = 1'b1;
    end
  endtask

  // Ends a run of frames with the same ready mode and checks what that mode is about
  task automatic close_phase();
    wait_drained();
    if (ready_mode == 2'd2 && !saw_src_stall) begin
      $display("src_ready_o never fell while dst_ready_i was held low");
      tb_errs++;
    end
    if (ready_mode == 2'd3 && (rate_bytes == 0 || rate_last - rate_first > 2 * rate_bytes)) begin
      $display("Output too slow, %0d bytes took %0d destination cycles", rate_bytes,
               rate_last - rate_first);
      tb_errs++;
    end
    @(posedge src_clk);
    #1;
  endtask

  initial begin
    int f;
    void'($urandom(32'he34a_172c));
    arst_n     = 1'b0;
    src_valid  = 1'b0;
    src_data   = 8'h00;
    src_last   = 1'b0;
    ready_mode = 2'd0;
    rate_on    = 1'b0;
    run_end    = 1'b0;
    aborted    = 1'b0;
    tb_errs    = 0;
    sent_cnt   = 0;
    repeat (10) @(posedge dst_clk);
    #1 arst_n = 1'b1;
    // Link must sit idle and ready with no input
    repeat (8) begin
      @(posedge dst_clk);
      expect_bit("dst_valid_o", 1'b0, dst_valid);
      expect_bit("src_ready_o", 1'b1, src_ready);
    end
    @(posedge src_clk);
    #1;
    for (f = 0; f < n_frames_lp && !aborted; f++) begin
      if (frame_tab[f].mode != ready_mode) begin
        close_phase();
        ready_mode = frame_tab[f].mode;
        rate_on    = (frame_tab[f].mode == 2'd3);
      end
      send_frame(frame_tab[f]);
    end
    if (!aborted) close_phase();
    run_end = 1'b1;
    repeat (3) @(posedge dst_clk);
    $display("Errors: data %0d, last %0d, other %0d, testbench %0d, assertions %0d",
             data_errs, last_errs, misc_errs, tb_errs, uut.u_chk.assert_errs);
    if (data_errs + last_errs + misc_errs + tb_errs + uut.u_chk.assert_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/link_monitor.sv ====
/*
 * Scoreboard for the byte link. Accepted source bytes are queued with their
 * last flag and every accepted output byte must match the head of the queue.
 */
`timescale 1ns/1ns

module link_monitor (
  input  logic       src_clk_i,
  input  logic       dst_clk_i,
  input  logic       arst_n_i,
  input  logic       src_valid_i,
  input  logic       src_ready_i,
  input  logic [7:0] src_data_i,
  input  logic       src_last_i,
  input  logic       dst_valid_i,
  input  logic       dst_ready_i,
  input  logic [7:0] dst_data_i,
  input  logic       dst_last_i,
  input  logic       end_i,
  output int         recv_cnt_o,
  output int         data_errs_o,
  output int         last_errs_o,
  output int         misc_errs_o
);

  // Each entry holds the last flag above the data byte
  logic [8:0] exp_q [$];
  logic [8:0] exp_byte;
  logic       end_done;

  always @(posedge src_clk_i) begin
    if (arst_n_i && src_valid_i && src_ready_i) begin
      exp_q.push_back({src_last_i, src_data_i});
    end
  end

  always @(posedge dst_clk_i) begin
    if (!arst_n_i) begin
      recv_cnt_o  <= 0;
      data_errs_o <= 0;
      last_errs_o <= 0;
      misc_errs_o <= 0;
      end_done = 1'b0;
    end else begin
      if (dst_valid_i && dst_ready_i) begin
        recv_cnt_o <= recv_cnt_o + 1;
        if (exp_q.size() == 0) begin
          $display("Output byte %h at %0t has no input byte to match", dst_data_i, $time);
          misc_errs_o <= misc_errs_o + 1;
        end else begin
          exp_byte = exp_q.pop_front();
          if (dst_data_i !== exp_byte[7:0]) begin
            $display("Fail t=%0t dst_data_o expected %h got %h", $time, exp_byte[7:0],
                     dst_data_i);
            data_errs_o <= data_errs_o + 1;
          end
          if (dst_last_i !== exp_byte[8]) begin
            $display("Fail t=%0t dst_last_o expected %b got %b", $time, exp_byte[8],
                     dst_last_i);
            last_errs_o <= last_errs_o + 1;
          end
        end
      end
      // Anything still queued at the end was lost inside the link
      if (end_i && !end_done) begin
        end_done = 1'b1;
        if (exp_q.size() != 0) begin
          $display("%0d input bytes never came out of the link", exp_q.size());
          misc_errs_o <= misc_errs_o + 1;
        end
      end
    end
  end

endmodule

// ==== tests/iso_link_chk.sv ====
/*
 * Handshake and reset assertions for the byte link.
 * Bound to the top level by the testbench, which also reads the failure count.
 */
`timescale 1ns/1ns

module iso_link_chk (
  input logic       src_clk_i,
  input logic       dst_clk_i,
  input logic       arst_n_i,
  input logic       src_valid_i,
  input logic       src_ready_o,
  input logic [7:0] src_data_i,
  input logic       src_last_i,
  input logic       dst_valid_o,
  input logic       dst_ready_i,
  input logic [7:0] dst_data_o,
  input logic       dst_last_o
);

  int assert_errs = 0;

  // A stalled source byte keeps its valid and payload
  src_hold: assert property (@(posedge src_clk_i) disable iff (!arst_n_i)
    src_valid_i && !src_ready_o |=> src_valid_i && $stable(src_data_i) && $stable(src_last_i))
    else begin
      $error("source byte changed while stalled");
      assert_errs++;
    end

  // Same rule on the output side of the unpacker
  dst_hold: assert property (@(posedge dst_clk_i) disable iff (!arst_n_i)
    dst_valid_o && !dst_ready_i |=> dst_valid_o && $stable(dst_data_o) && $stable(dst_last_o))
    else begin
      $error("output byte changed while stalled");
      assert_errs++;
    end

  last_needs_valid: assert property (@(posedge dst_clk_i) disable iff (!arst_n_i)
    dst_last_o |-> dst_valid_o)
    else begin
      $error("dst_last_o high without dst_valid_o");
      assert_errs++;
    end

  // First edge out of reset sees an empty link ready for input
  reset_state: assert property (@(posedge dst_clk_i)
    $rose(arst_n_i) |-> src_ready_o && !dst_valid_o)
    else begin
      $error("wrong ready or valid right after reset");
      assert_errs++;
    end

endmodule

// ==== rtl/iso_byte_link.sv ====
/*
 * Top level of the byte link from the slow source clock to the fast
 * destination clock. Bytes are packed, crossed as words and unpacked again.
 */
`timescale 1ns/1ns

module iso_byte_link (
  // Source domain, the destination clock divided by two with aligned edges
  input  logic       src_clk_i,
  input  logic       src_valid_i,
  output logic       src_ready_o,
  input  logic [7:0] src_data_i,
  input  logic       src_last_i,

  // Destination domain
  input  logic       dst_clk_i,
  output logic       dst_valid_o,
  input  logic       dst_ready_i,
  output logic [7:0] dst_data_o,
  output logic       dst_last_o,

  // Shared asynchronous reset for both domains
  input  logic       arst_n_i
);

  // Word channel in the source domain, packer to crossing
  iso_word_if src_word ();
  // Word channel in the destination domain, crossing to unpacker
  iso_word_if dst_word ();

  byte_packer u_packer (
    .src_clk_i    (src_clk_i),
    .arst_n_i     (arst_n_i),
    .byte_valid_i (src_valid_i),
    .byte_ready_o (src_ready_o),
    .byte_data_i  (src_data_i),
    .byte_last_i  (src_last_i),
    .word_o       (src_word.sender)
  );

  // Holds up to two words while the destination stalls
  isochronous_spill_register u_crossing (
    .src_clk_i (src_clk_i),
    .dst_clk_i (dst_clk_i),
    .arst_n_i  (arst_n_i),
    .src_o     (src_word.receiver),
    .dst_o     (dst_word.sender)
  );

  byte_unpacker u_unpacker (
    .dst_clk_i    (dst_clk_i),
    .arst_n_i     (arst_n_i),
    .word_i       (dst_word.receiver),
    .byte_valid_o (dst_valid_o),
    .byte_ready_i (dst_ready_i),
    .byte_data_o  (dst_data_o),
    .byte_last_o  (dst_last_o)
  );

endmodule

// ==== rtl/byte_unpacker.sv ====
/*
 * Destination-domain unpacker that sends the valid bytes of each word in order.
 * The last flag goes out with the final byte of a frame-ending word.
 */
`timescale 1ns/1ns

module byte_unpacker (
  input  logic         dst_clk_i,
  input  logic         arst_n_i,
  iso_word_if.receiver word_i,
  output logic         byte_valid_o,
  input  logic         byte_ready_i,
  output logic [7:0]   byte_data_o,
  output logic         byte_last_o
);
  import iso_link_pkg::*;

  unpack_state_e state_q;

  // Holding register for the word being sent
  logic [8*word_bytes_lp-1:0] hold_data_q;
  logic [count_w_lp-1:0]      hold_nbytes_q;
  logic                       hold_last_q;

  // Index of the byte currently on the output
  logic [count_w_lp-1:0]      idx_q;

  logic final_byte;
  logic byte_fire;
  logic word_take;

  assign final_byte = (idx_q + count_w_lp'(1)) == hold_nbytes_q;

  assign byte_valid_o = (state_q == SENDING);
  assign byte_data_o  = hold_data_q[8*idx_q[1:0] +: 8];
  assign byte_last_o  = byte_valid_o && final_byte && hold_last_q;

  assign byte_fire = byte_valid_o && byte_ready_i;

  // Take a new word when idle, or as the final byte leaves so streaming
  // continues without a bubble
  assign word_i.ready = (state_q == IDLE) || (byte_fire && final_byte);
  assign word_take    = word_i.valid && word_i.ready;

  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else begin
      if (word_take) begin
        state_q <= SENDING;
        idx_q   <= '0;
      end else if (byte_fire && final_byte) begin
        state_q <= IDLE;
      end else if (byte_fire) begin
        idx_q <= idx_q + count_w_lp'(1);
      end
    end
  end

  // Capture the payload of the word being taken
  always_ff @(posedge dst_clk_i) begin
    if (word_take) begin
      hold_data_q   <= word_i.data;
      hold_nbytes_q <= word_i.nbytes;
      hold_last_q   <= word_i.last;
    end
  end

endmodule

// ==== rtl/isochronous_spill_register.sv ====
/*
 * Two-entry buffer carrying words between clocks derived from one source.
 * Pointers live in separate domains; static timing covers the crossing paths.
 */
`timescale 1ns/1ns

module isochronous_spill_register (
  input  logic         src_clk_i,
  input  logic         dst_clk_i,
  input  logic         arst_n_i,
  iso_word_if.receiver src_o,
  iso_word_if.sender   dst_o
);
  import iso_link_pkg::*;

  // Pointers carry one extra top bit
  // Equal pointers mean empty, pointers that differ only in the top bit mean full
  logic [1:0] wr_ptr_q;
  logic [1:0] rd_ptr_q;

  xfer_word_t mem_q [2];
  xfer_word_t src_word;
  xfer_word_t dst_word;

  logic src_push;
  logic dst_pop;

  // Pack the source channel fields for storage
  assign src_word.data   = src_o.data;
  assign src_word.nbytes = src_o.nbytes;
  assign src_word.last   = src_o.last;

  // Not full, seen from the source domain
  assign src_o.ready = (rd_ptr_q ^ wr_ptr_q) != 2'b10;
  // Not empty, seen from the destination domain
  assign dst_o.valid = (rd_ptr_q ^ wr_ptr_q) != 2'b00;

  assign src_push = src_o.valid && src_o.ready;
  assign dst_pop  = dst_o.valid && dst_o.ready;

  // Write side runs on the slow clock
  always_ff @(posedge src_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= 2'b00;
    end else if (src_push) begin
      wr_ptr_q <= wr_ptr_q + 2'd1;
    end
  end

  always_ff @(posedge src_clk_i) begin
    if (src_push) begin
      mem_q[wr_ptr_q[0]] <= src_word;
    end
  end

  // Read side runs on the fast clock
  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= 2'b00;
    end else if (dst_pop) begin
      rd_ptr_q <= rd_ptr_q + 2'd1;
    end
  end

  // The entry under the read pointer is stable until popped
  assign dst_word     = mem_q[rd_ptr_q[0]];
  assign dst_o.data   = dst_word.data;
  assign dst_o.nbytes = dst_word.nbytes;
  assign dst_o.last   = dst_word.last;

endmodule

// ==== rtl/byte_packer.sv ====
/*
 * Source-domain packer that gathers bytes into words for the crossing.
 * A last byte flushes a partly filled word early.
 */
`timescale 1ns/1ns

module byte_packer (
  input  logic              src_clk_i,
  input  logic              arst_n_i,
  input  logic              byte_valid_i,
  output logic              byte_ready_o,
  input  logic [7:0]        byte_data_i,
  input  logic              byte_last_i,
  iso_word_if.sender        word_o
);
  import iso_link_pkg::*;

  // Assembly register and the number of bytes it already holds
  logic [8*word_bytes_lp-1:0] asm_data_q;
  logic [count_w_lp-1:0]      asm_cnt_q;
  logic [8*word_bytes_lp-1:0] asm_merged;

  // Output register that drives the word channel
  pack_state_e                out_state_q;
  logic [8*word_bytes_lp-1:0] out_data_q;
  logic [count_w_lp-1:0]      out_nbytes_q;
  logic                       out_last_q;

  logic word_done;
  logic byte_fire;
  logic word_load;
  logic out_take;

  // Incoming byte slotted into the assembly word at the current count
  always_comb begin
    asm_merged = asm_data_q;
    asm_merged[8*asm_cnt_q[1:0] +: 8] = byte_data_i;
  end

  // The offered byte fills the word or ends the frame
  assign word_done = (asm_cnt_q == count_w_lp'(word_bytes_lp - 1)) || byte_last_i;

  assign out_take = (out_state_q == OUT_FULL) && word_o.ready;

  // Hold off only when a finished word would overwrite a word still waiting
  // If the crossing takes the held word this cycle the new one loads in its place
  assign byte_ready_o = !(word_done && (out_state_q == OUT_FULL) && !word_o.ready);

  assign byte_fire = byte_valid_i && byte_ready_o;
  assign word_load = byte_fire && word_done;

  always_ff @(posedge src_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      asm_cnt_q   <= '0;
      out_state_q <= OUT_EMPTY;
    end else begin
      if (byte_fire) begin
        asm_cnt_q <= word_done ? '0 : asm_cnt_q + count_w_lp'(1);
      end
      // A load while the old word leaves keeps the register full
      if (word_load) begin
        out_state_q <= OUT_FULL;
      end else if (out_take) begin
        out_state_q <= OUT_EMPTY;
      end
    end
  end

  // Payloads load with an accepted byte and with a finished word
  always_ff @(posedge src_clk_i) begin
    if (byte_fire) begin
      asm_data_q <= asm_merged;
    end
    if (word_load) begin
      out_data_q   <= asm_merged;
      out_nbytes_q <= asm_cnt_q + count_w_lp'(1);
      out_last_q   <= byte_last_i;
    end
  end

  assign word_o.valid  = (out_state_q == OUT_FULL);
  assign word_o.data   = out_data_q;
  assign word_o.nbytes = out_nbytes_q;
  assign word_o.last   = out_last_q;

endmodule

// ==== rtl/iso_word_if.sv ====
/*
 * Word channel with valid/ready handshake, one clock domain per instance.
 * The sender drives the payload and valid, the receiver drives ready.
 */
`timescale 1ns/1ns

interface iso_word_if;
  import iso_link_pkg::*;

  // Handshake pair
  logic                       valid;
  logic                       ready;

  // Payload, the first byte in the lowest bits
  logic [8*word_bytes_lp-1:0] data;
  // Number of valid bytes counted from the lowest byte
  logic [count_w_lp-1:0]      nbytes;
  // Set when the word closes a frame
  logic                       last;

  modport sender (
    output valid,
    output data,
    output nbytes,
    output last,
    input  ready
  );

  modport receiver (
    input  valid,
    input  data,
    input  nbytes,
    input  last,
    output ready
  );

endinterface

// ==== rtl/iso_link_pkg.sv ====
/*
 * Shared types and constants for the byte link across isochronous clocks.
 * Imported by the packer, crossing, unpacker and the word interface.
 */
package iso_link_pkg;

  // Bytes carried by one crossing word
  localparam int word_bytes_lp = 4;

  // Byte count width, holds 1 to word_bytes_lp
  localparam int count_w_lp = 3;

  // Word as stored in the crossing memory
  // The first byte of a word sits in the lowest data bits
  typedef struct packed {
    logic                       last;
    logic [count_w_lp-1:0]      nbytes;
    logic [8*word_bytes_lp-1:0] data;
  } xfer_word_t;

  // Packer output register occupancy
  typedef enum logic {
    OUT_EMPTY,
    OUT_FULL
  } pack_state_e;

  // Unpacker byte sequencing
  typedef enum logic {
    IDLE,
    SENDING
  } unpack_state_e;

endpackage
